//--- tb/frame_input.hex
// Word 0: frame count. Then each frame: one pixel per line, row-major, 4 per row.
// Pixel digits are blue, green, red from left to right (red is the low digit).
002
// Frame 0
00f
0f0
f00
fff
001
012
123
234
345
456
567
678
789
89a
9ab
abc
bcd
cde
def
ef0
f01
102
203
304
8c4
4c8
c48
000
7e1
e17
17e
555
// Frame 1
fff
000
a5a
5a5
100
010
001
111
0f8
f80
80f
777
2c6
6c2
c26
999
e00
0e0
00e
eee
3b7
b73
73b
444
9d1
d19
19d
888
654
543
432
321

//--- src.f
source/led_pkg.sv
source/frame_ram.sv
source/spi_frame_receiver.sv
source/row_scanner.sv
source/buffer_controller.sv
source/led_matrix_driver.sv
tb/led_matrix_checker.sv
tb/led_matrix_driver_tb.sv

//--- Makefile
# Verilator build and run of the LED matrix driver testbench.

VERILATOR   ?= verilator
TOP         := led_matrix_driver_tb
FILELIST    := src.f
OBJ_DIR     := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

# The log decides the result, since the simulator exits cleanly either way.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/led_matrix_driver_tb.sv
`timescale 1ns/10ps

// Testbench for the LED matrix driver on a small 4 by 8 panel.
// Frames come from the input file and go out over SPI.
// The monitor does all comparing.
module led_matrix_driver_tb import led_pkg::*;;

    localparam int COL_BITS = 2;
    localparam int ROW_BITS = 2;
    localparam int MAX_FRAMES = 2;
    localparam int PIXELS = 2 ** (COL_BITS + ROW_BITS + 1);

    // Which monitor count a wait looks at.
    localparam int EV_START = 0;
    localparam int EV_DONE = 1;
    localparam int EV_RECEIVED = 2;
    localparam int EV_SHOWN = 3;

    // One refresh of this panel is a few thousand cycles.
    localparam int LONG_LIMIT = 10000;
    localparam int SHORT_LIMIT = 100;

    logic                clk;
    logic                reset;
    logic                sck;
    logic                sdi;
    logic [2:0]          upper_rgb;
    logic [2:0]          lower_rgb;
    logic [ROW_BITS-1:0] row_sel;
    logic                mclk;
    logic                latch;
    logic                oe;
    logic                refresh_done;
    logic                refresh_start;
    logic                frame_ready;

    int error_count;
    int check_count;
    int frames_received;
    int frames_shown;
    int refresh_starts;
    int refresh_dones;
    int frame_count;
    logic aborted;

    logic [PIX_BITS-1:0] file_words [0:MAX_FRAMES*PIXELS];

    led_matrix_driver #(
        .COL_BITS(COL_BITS),
        .ROW_BITS(ROW_BITS)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .sck(sck),
        .sdi(sdi),
        .upper_rgb(upper_rgb),
        .lower_rgb(lower_rgb),
        .row_sel(row_sel),
        .mclk(mclk),
        .latch(latch),
        .oe(oe),
        .refresh_done(refresh_done),
        .refresh_start(refresh_start),
        .frame_ready(frame_ready)
    );

    led_matrix_checker #(
        .COL_BITS(COL_BITS),
        .ROW_BITS(ROW_BITS),
        .MAX_FRAMES(MAX_FRAMES)
    ) monitor (
        .clk(clk),
        .reset(reset),
        .upper_rgb(upper_rgb),
        .lower_rgb(lower_rgb),
        .row_sel(row_sel),
        .mclk(mclk),
        .latch(latch),
        .oe(oe),
        .refresh_start(refresh_start),
        .refresh_done(refresh_done),
        .frame_ready(frame_ready),
        .error_count(error_count),
        .check_count(check_count),
        .frames_received(frames_received),
        .frames_shown(frames_shown),
        .refresh_starts(refresh_starts),
        .refresh_dones(refresh_dones)
    );

    // 20 ns clock period.
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // SPI host
    ////////////////////////////////////////////////////////////

    // Each serial clock level lasts 4 clk cycles, and data changes while it is low.
    task automatic send_bit(input logic b);
        @(posedge clk);
        sck <= 1'b0;
        sdi <= b;
        repeat (4) @(posedge clk);
        sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // Pixels go out in row-major order, each one LSB first.
    task automatic send_frame(input int f);
        logic [PIX_BITS-1:0] word;
        for (int p = 0; p < PIXELS; p++) begin
            word = file_words[1 + f * PIXELS + p];
            for (int b = 0; b < PIX_BITS; b++) begin
                send_bit(word[b]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////

    function automatic int event_count(input int which);
        case (which)
            EV_START:    return refresh_starts;
            EV_DONE:     return refresh_dones;
            EV_RECEIVED: return frames_received;
            default:     return frames_shown;
        endcase
    endfunction

    // Monitor counts change on the falling edge, so they are read on the rising one.
    task automatic wait_for_count(input int which, input int target,
                                  input string what, input int limit);
        int cycles;
        cycles = 0;
        while (!aborted && event_count(which) < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timed out after %0d cycles waiting for %s.", limit, what);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic run_frames();
        int base;
        if (frame_count < 1 || frame_count > MAX_FRAMES) begin
            $display("The input file gives %0d frames, which this bench cannot run.",
                     frame_count);
            aborted = 1'b1;
            return;
        end
        wait_for_count(EV_START, 1, "the first refresh to start", LONG_LIMIT);
        if (aborted) return;
        for (int f = 0; f < frame_count; f++) begin
            // Later frames go out while the previous one is on the panel.
            if (f > 0) begin
                wait_for_count(EV_SHOWN, f, "the previous frame to be copied", LONG_LIMIT);
                if (aborted) return;
                base = refresh_starts;
                wait_for_count(EV_START, base + 1, "the refresh of the copied frame",
                               LONG_LIMIT);
                if (aborted) return;
            end
            send_frame(f);
            wait_for_count(EV_RECEIVED, f + 1, "frame_ready after a full frame", SHORT_LIMIT);
            if (aborted) return;
        end
        wait_for_count(EV_SHOWN, frame_count, "the last frame to be copied", LONG_LIMIT);
        if (aborted) return;
        // One whole refresh of the last frame is checked.
        base = refresh_dones;
        wait_for_count(EV_DONE, base + 1, "the refresh of the last frame to end", LONG_LIMIT);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, frames received: %0d, frames shown: %0d",
                 check_count, error_count, frames_received, frames_shown);
        if (aborted || error_count != 0 || frames_shown != frame_count) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        sck = 1'b0;
        sdi = 1'b0;
        aborted = 1'b0;
        $readmemh("tb/frame_input.hex", file_words);
        frame_count = int'(file_words[0]);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        run_frames();
        finish_run();
    end

endmodule

//--- tb/led_matrix_checker.sv
`timescale 1ns/10ps

// Panel monitor for the LED matrix driver.
// It rebuilds each shifted row from the panel pins and compares it with the
// frame that should be on display at that moment.
module led_matrix_checker import led_pkg::*; #(
    parameter int COL_BITS = 2,
    parameter int ROW_BITS = 2,
    parameter int MAX_FRAMES = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [2:0]          upper_rgb,
    input  logic [2:0]          lower_rgb,
    input  logic [ROW_BITS-1:0] row_sel,
    input  logic                mclk,
    input  logic                latch,
    input  logic                oe,
    input  logic                refresh_start,
    input  logic                refresh_done,
    input  logic                frame_ready,
    output int                  error_count,
    output int                  check_count,
    output int                  frames_received,
    output int                  frames_shown,
    output int                  refresh_starts,
    output int                  refresh_dones
);

    localparam int PIXELS = 2 ** (COL_BITS + ROW_BITS + 1);
    localparam int COLS = 2 ** COL_BITS;
    localparam int PASSES = 2 ** COLOR_DEPTH;
    localparam int LAST_ROW = 2 ** ROW_BITS - 1;

    // Word 0 is the frame count, the frames follow it back to back.
    logic [PIX_BITS-1:0] file_words [0:MAX_FRAMES*PIXELS];

    // The frame that the display buffers should hold right now.
    pixel_t shown [0:PIXELS-1];

    logic                   mclk_prev;
    logic                   latch_prev;
    logic [ROW_BITS-1:0]    row_prev;
    logic [ROW_BITS-1:0]    next_row;
    logic [COLOR_DEPTH-1:0] level;
    logic                   pending;
    int                     col_count;
    int                     pass_count;
    int                     base;

    initial begin
        $readmemh("tb/frame_input.hex", file_words);
    end

    // A channel is on in a pass when its value is above that pass's level.
    function automatic logic [2:0] expected_rgb(input pixel_t pix,
                                                input logic [COLOR_DEPTH-1:0] lvl);
        logic [2:0] bits;
        bits[0] = (pix.red > lvl);
        bits[1] = (pix.green > lvl);
        bits[2] = (pix.blue > lvl);
        return bits;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_fault(input string what);
        error_count++;
        $display("Checker fault at %0t: %s.", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Sampling on the falling edge, where every pin is settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (reset) begin
            error_count = 0;
            check_count = 0;
            frames_received = 0;
            frames_shown = 0;
            refresh_starts = 0;
            refresh_dones = 0;
            mclk_prev = 1'b0;
            latch_prev = 1'b0;
            row_prev = '0;
            level = '0;
            pending = 1'b0;
            col_count = 0;
            pass_count = 0;
            // The controller clears the display buffers after reset.
            for (int p = 0; p < PIXELS; p++) begin
                shown[p] = '0;
            end
        end else begin
            // Nothing may light or latch before the first refresh.
            if (refresh_starts == 0) begin
                compare_value("idle outputs", 0, int'({latch, oe, upper_rgb, lower_rgb}));
            end
            // The panel is blanked exactly while a row is latched.
            compare_value("oe against latch", int'(latch), int'(oe));
            if (refresh_start) begin
                // A refresh only starts once the previous one has ended.
                compare_value("refreshes ended before a start", refresh_starts, refresh_dones);
                refresh_starts++;
            end
            if (frame_ready) begin
                // The receiver holds each frame until it has been copied for display.
                compare_value("frames shown before a new frame", frames_received, frames_shown);
                frames_received++;
                pending = 1'b1;
            end

            // A new row pair starts its PWM passes from level zero.
            if (row_sel != row_prev) begin
                if (oe) begin
                    report_fault("row select changed while the output enable was high");
                end
                next_row = row_prev + 1'b1;
                compare_value("row order", int'(next_row), int'(row_sel));
                compare_value("passes per row", PASSES, pass_count);
                level = '0;
                pass_count = 0;
            end

            // The latch closes a pass, so the level steps here.
            if (latch && !latch_prev) begin
                compare_value("mclk edges per pass", COLS, col_count);
                col_count = 0;
                level = level + 1'b1;
                pass_count++;
            end

            // Column k of the pass is presented at the k-th rising edge of mclk.
            if (mclk && !mclk_prev) begin
                if (col_count < COLS) begin
                    base = int'(row_sel) * COLS + col_count;
                    compare_value($sformatf("upper_rgb row %0d col %0d level %0d",
                                            row_sel, col_count, level),
                                  int'(expected_rgb(shown[base], level)), int'(upper_rgb));
                    compare_value($sformatf("lower_rgb row %0d col %0d level %0d",
                                            int'(row_sel) + LAST_ROW + 1, col_count, level),
                                  int'(expected_rgb(shown[PIXELS/2 + base], level)),
                                  int'(lower_rgb));
                end
                col_count++;
            end

            // A frame finished during this refresh goes on display for the next one.
            if (refresh_done) begin
                compare_value("refresh starts at refresh done", refresh_dones + 1,
                              refresh_starts);
                refresh_dones++;
                compare_value("last row before refresh done", LAST_ROW, int'(row_sel));
                compare_value("passes per row", PASSES, pass_count);
                if (pending) begin
                    if (frames_shown < MAX_FRAMES) begin
                        for (int p = 0; p < PIXELS; p++) begin
                            shown[p] = pixel_t'(file_words[1 + frames_shown * PIXELS + p]);
                        end
                    end else begin
                        report_fault("more frames arrived than the input file holds");
                    end
                    frames_shown++;
                    pending = 1'b0;
                end
            end

            mclk_prev = mclk;
            latch_prev = latch;
            row_prev = row_sel;
        end
    end

endmodule

//--- source/led_matrix_driver.sv
`timescale 1ns/10ps

// Driver for a split RGB LED matrix, loaded with whole frames over SPI.
// The receiver and the scanner run side by side.
// The controller moves finished frames between their buffers.
module led_matrix_driver import led_pkg::*; #(
    parameter int COL_BITS = 5,
    parameter int ROW_BITS = 4,
    parameter int MCLK_DIV_BITS = 3,
    parameter int LATCH_BITS = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                sck,
    input  logic                sdi,
    output logic [2:0]          upper_rgb,
    output logic [2:0]          lower_rgb,
    output logic [ROW_BITS-1:0] row_sel,
    output logic                mclk,
    output logic                latch,
    output logic                oe,
    output logic                refresh_done,
    output logic                refresh_start,
    output logic                frame_ready
);

    // Both halves of the panel, as one pixel address space.
    localparam int FRAME_BITS = COL_BITS + ROW_BITS + 1;

    logic                  copy_done;
    logic [FRAME_BITS-1:0] load_addr;
    logic [FRAME_BITS-1:0] copy_addr;
    pixel_t                load_pix;
    copy_word_t            copy_word;
    panel_drive_t          drive;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    spi_frame_receiver #(
        .FRAME_BITS(FRAME_BITS)
    ) receiver (
        .clk(clk),
        .reset(reset),
        .sck(sck),
        .sdi(sdi),
        .copy_done(copy_done),
        .load_addr(load_addr),
        .load_pix(load_pix),
        .frame_ready(frame_ready)
    );

    buffer_controller #(
        .FRAME_BITS(FRAME_BITS)
    ) controller (
        .clk(clk),
        .reset(reset),
        .frame_ready(frame_ready),
        .refresh_done(refresh_done),
        .load_pix(load_pix),
        .load_addr(load_addr),
        .copy_addr(copy_addr),
        .copy_word(copy_word),
        .copy_done(copy_done),
        .refresh_start(refresh_start)
    );

    row_scanner #(
        .COL_BITS(COL_BITS),
        .ROW_BITS(ROW_BITS),
        .MCLK_DIV_BITS(MCLK_DIV_BITS),
        .LATCH_BITS(LATCH_BITS)
    ) scanner (
        .clk(clk),
        .reset(reset),
        .copy_addr(copy_addr),
        .copy_word(copy_word),
        .refresh_start(refresh_start),
        .refresh_done(refresh_done),
        .row_sel(row_sel),
        .drive(drive)
    );

    // Panel pins.
    assign upper_rgb = drive.upper_rgb;
    assign lower_rgb = drive.lower_rgb;
    assign mclk      = drive.mclk;
    assign latch     = drive.latch;
    assign oe        = drive.oe;

endmodule

//--- source/buffer_controller.sv
`timescale 1ns/10ps

// Double-buffer sequencer between the load buffer and the display buffers.
// A new frame is copied only between refreshes, so the panel never tears.
module buffer_controller import led_pkg::*; #(
    parameter int FRAME_BITS = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_ready,
    input  logic                  refresh_done,
    input  pixel_t                load_pix,
    output logic [FRAME_BITS-1:0] load_addr,
    output logic [FRAME_BITS-1:0] copy_addr,
    output copy_word_t            copy_word,
    output logic                  copy_done,
    output logic                  refresh_start
);

    typedef enum logic [1:0] {CTL_CLEAR, CTL_REFRESH, CTL_COPY, CTL_START} ctl_state_t;

    ctl_state_t state, next_state;

    // The step counter runs over every address and one cycle more.
    // That extra cycle lets the last delayed write land.
    // Its top bit marks that cycle.
    logic [FRAME_BITS:0] step;
    logic                last_step;
    logic                walking;
    logic                pending;
    logic                write_q;
    logic                zero_q;

    assign last_step = step[FRAME_BITS];
    assign walking   = (state == CTL_CLEAR) || (state == CTL_COPY);
    assign load_addr = step[FRAME_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= CTL_CLEAR;
            step      <= '0;
            pending   <= 1'b0;
            write_q   <= 1'b0;
            copy_done <= 1'b0;
        end else begin
            state <= next_state;
            if (walking) begin
                step <= last_step ? '0 : step + 1'b1;
            end
            // A finished frame waits here until the current refresh is over.
            if (state == CTL_COPY) begin
                pending <= 1'b0;
            end else if (frame_ready) begin
                pending <= 1'b1;
            end
            // The write lags the read address by one cycle to match the RAM latency.
            write_q   <= walking && !last_step;
            copy_done <= (state == CTL_COPY) && last_step;
        end
    end

    // The delayed address and the zero select travel with write_q.
    always_ff @(posedge clk) begin
        copy_addr <= step[FRAME_BITS-1:0];
        zero_q    <= (state == CTL_CLEAR);
    end

    // After reset, zeros are written to every address, so the first refresh shows black.
    assign copy_word.we  = write_q;
    assign copy_word.pix = zero_q ? pixel_t'('0) : load_pix;

    always_comb begin
        next_state = state;
        case (state)
            CTL_CLEAR: next_state = last_step ? CTL_START : CTL_CLEAR;
            CTL_START: next_state = CTL_REFRESH;
            CTL_REFRESH: begin
                if (refresh_done) begin
                    next_state = (pending || frame_ready) ? CTL_COPY : CTL_START;
                end
            end
            CTL_COPY:  next_state = last_step ? CTL_START : CTL_COPY;
            default:   next_state = CTL_CLEAR;
        endcase
    end

    assign refresh_start = (state == CTL_START);

    // A refresh must not start while a copy is still in progress.
    // That includes the last delayed write.
    assert property (@(posedge clk) disable iff (reset) refresh_start |-> !copy_word.we);

endmodule

//--- source/row_scanner.sv
`timescale 1ns/10ps

// Panel refresh engine.
// Each row pair is shifted out 2^COLOR_DEPTH times, once per PWM level.
// Then the scanner moves on to the next pair.
module row_scanner import led_pkg::*; #(
    parameter int COL_BITS = 5,
    parameter int ROW_BITS = 4,
    parameter int MCLK_DIV_BITS = 3,
    parameter int LATCH_BITS = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [COL_BITS+ROW_BITS:0] copy_addr,
    input  copy_word_t                 copy_word,
    input  logic                       refresh_start,
    output logic                       refresh_done,
    output logic [ROW_BITS-1:0]        row_sel,
    output panel_drive_t               drive
);

    // Address bits of one panel half.
    localparam int HALF_BITS = COL_BITS + ROW_BITS;

    typedef enum logic [1:0] {SCAN_IDLE, SCAN_SHIFT, SCAN_LATCH, SCAN_DONE} scan_state_t;

    scan_state_t state, next_state;

    logic [COL_BITS-1:0]      col;
    logic [ROW_BITS-1:0]      row;
    logic [MCLK_DIV_BITS-1:0] mclk_div;
    logic [LATCH_BITS-1:0]    latch_cnt;
    logic [COLOR_DEPTH-1:0]   pwm_cnt;
    logic [HALF_BITS-1:0]     ram_addr;
    logic                     upper_we, lower_we;
    pixel_t                   upper_pix, lower_pix;
    logic                     col_end, pass_end, latch_end, frame_end;

    // A channel is lit in this pass if its value is above the PWM level.
    function automatic logic [2:0] lit(input pixel_t pix, input logic [COLOR_DEPTH-1:0] level);
        lit = {pix.blue > level, pix.green > level, pix.red > level};
    endfunction

    ////////////////////////////////////////////////////////////
    // Display buffers
    ////////////////////////////////////////////////////////////

    // The top address bit picks the half, so both halves can be read in the same cycle.
    // The copy address is only used while idle, and the controller writes only then.
    assign ram_addr = (state == SCAN_IDLE) ? copy_addr[HALF_BITS-1:0] : {row, col};
    assign upper_we = copy_word.we && !copy_addr[HALF_BITS];
    assign lower_we = copy_word.we && copy_addr[HALF_BITS];

    frame_ram #(
        .WIDTH(PIX_BITS),
        .DEPTH_BITS(HALF_BITS)
    ) upper_ram (
        .clk(clk),
        .we(upper_we),
        .addr(ram_addr),
        .wdata(copy_word.pix),
        .rdata(upper_pix)
    );

    frame_ram #(
        .WIDTH(PIX_BITS),
        .DEPTH_BITS(HALF_BITS)
    ) lower_ram (
        .clk(clk),
        .we(lower_we),
        .addr(ram_addr),
        .wdata(copy_word.pix),
        .rdata(lower_pix)
    );

    ////////////////////////////////////////////////////////////
    // Scan sequencing
    ////////////////////////////////////////////////////////////

    assign col_end   = (mclk_div == '1);
    assign pass_end  = col_end && (col == '1);
    assign latch_end = (latch_cnt == '1);
    assign frame_end = (pwm_cnt == '1) && (row == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SCAN_IDLE;
            col       <= '0;
            row       <= '0;
            mclk_div  <= '0;
            latch_cnt <= '0;
            pwm_cnt   <= '0;
            row_sel   <= '0;
            drive     <= '0;
        end else begin
            state <= next_state;

            // The column advances once per matrix clock period.
            if (state == SCAN_SHIFT) begin
                mclk_div <= mclk_div + 1'b1;
                if (col_end) begin
                    col <= col + 1'b1;
                end
            end

            // The new row pair is shown at the start of its first pass.
            // The output enable is already low by then.
            if (state == SCAN_SHIFT && pwm_cnt == '0 && col == '0 && mclk_div == '0) begin
                row_sel <= row;
            end

            // The PWM level steps after every latch, and the row after the level wraps.
            if (state == SCAN_LATCH) begin
                latch_cnt <= latch_cnt + 1'b1;
                if (latch_end) begin
                    pwm_cnt <= pwm_cnt + 1'b1;
                    if (pwm_cnt == '1) begin
                        row <= row + 1'b1;
                    end
                end
            end

            // All panel outputs are registered so they leave the chip together.
            // RAM data for a column is valid from the second cycle of its period.
            // Mclk rises in the second half, well after that.
            drive.upper_rgb <= (state == SCAN_SHIFT) ? lit(upper_pix, pwm_cnt) : 3'b000;
            drive.lower_rgb <= (state == SCAN_SHIFT) ? lit(lower_pix, pwm_cnt) : 3'b000;
            drive.mclk      <= (state == SCAN_SHIFT) && mclk_div[MCLK_DIV_BITS-1];
            drive.latch     <= (state == SCAN_LATCH);
            drive.oe        <= (state == SCAN_LATCH);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SCAN_IDLE:  next_state = refresh_start ? SCAN_SHIFT : SCAN_IDLE;
            SCAN_SHIFT: next_state = pass_end ? SCAN_LATCH : SCAN_SHIFT;
            SCAN_LATCH: begin
                if (latch_end) begin
                    next_state = frame_end ? SCAN_DONE : SCAN_SHIFT;
                end
            end
            SCAN_DONE:  next_state = SCAN_IDLE;
            default:    next_state = SCAN_IDLE;
        endcase
    end

    assign refresh_done = (state == SCAN_DONE);

    // The display buffers may only be written while no refresh reads them.
    assert property (@(posedge clk) disable iff (reset) copy_word.we |-> state == SCAN_IDLE);

endmodule

//--- source/spi_frame_receiver.sv
`timescale 1ns/10ps

// Receive-only SPI link that fills the load buffer one frame at a time.
// Once the frame is full, the block freezes and lends its RAM to the controller.
module spi_frame_receiver import led_pkg::*; #(
    parameter int FRAME_BITS = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sck,
    input  logic                  sdi,
    input  logic                  copy_done,
    input  logic [FRAME_BITS-1:0] load_addr,
    output pixel_t                load_pix,
    output logic                  frame_ready
);

    typedef enum logic [1:0] {RX_RECV, RX_WRITE, RX_HOLD} rx_state_t;

    rx_state_t state, next_state;

    // Two-flop synchronizers, plus one more flop on sck for the edge detect.
    logic sck_meta, sck_sync, sck_prev;
    logic sdi_meta, sdi_sync;
    logic sck_rise;

    logic [$clog2(PIX_BITS)-1:0] bit_cnt;
    logic [PIX_BITS-1:0]         shift_reg;
    logic [FRAME_BITS-1:0]       wr_addr;
    logic [FRAME_BITS-1:0]       ram_addr;
    logic                        ram_we;

    ////////////////////////////////////////////////////////////
    // Serial input
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_meta <= 1'b0;
            sck_sync <= 1'b0;
            sck_prev <= 1'b0;
            sdi_meta <= 1'b0;
            sdi_sync <= 1'b0;
        end else begin
            sck_meta <= sck;
            sck_sync <= sck_meta;
            sck_prev <= sck_sync;
            sdi_meta <= sdi;
            sdi_sync <= sdi_meta;
        end
    end

    // A bit is taken 2 cycles after its SPI clock edge.
    assign sck_rise = sck_sync && !sck_prev;

    ////////////////////////////////////////////////////////////
    // Pixel assembly and frame bookkeeping
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_RECV;
            bit_cnt <= '0;
            wr_addr <= '0;
        end else begin
            state <= next_state;
            // Edges seen outside RX_RECV are dropped on purpose.
            // The host has to wait for the copy to finish.
            if (state == RX_RECV && sck_rise) begin
                bit_cnt <= (bit_cnt == PIX_BITS - 1) ? '0 : bit_cnt + 1'b1;
            end
            // The address wraps to zero after the last pixel, ready for the next frame.
            if (state == RX_WRITE) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // New bits enter at the top, so the first bit ends up in the LSB.
    always_ff @(posedge clk) begin
        if (state == RX_RECV && sck_rise) begin
            shift_reg <= {sdi_sync, shift_reg[PIX_BITS-1:1]};
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RX_RECV: begin
                if (sck_rise && bit_cnt == PIX_BITS - 1) begin
                    next_state = RX_WRITE;
                end
            end
            RX_WRITE: next_state = (wr_addr == '1) ? RX_HOLD : RX_RECV;
            RX_HOLD:  next_state = copy_done ? RX_RECV : RX_HOLD;
            default:  next_state = RX_RECV;
        endcase
    end

    // The RAM is ours while we receive.
    // While we hold, the controller drives the address.
    assign ram_we      = (state == RX_WRITE);
    assign ram_addr    = (state == RX_HOLD) ? load_addr : wr_addr;
    assign frame_ready = (state == RX_WRITE) && (wr_addr == '1);

    frame_ram #(
        .WIDTH(PIX_BITS),
        .DEPTH_BITS(FRAME_BITS)
    ) load_ram (
        .clk(clk),
        .we(ram_we),
        .addr(ram_addr),
        .wdata(shift_reg),
        .rdata(load_pix)
    );

    // The controller may only finish a copy of a frame that we are holding.
    assert property (@(posedge clk) disable iff (reset) copy_done |-> state == RX_HOLD);

endmodule

//--- source/frame_ram.sv
`timescale 1ns/10ps

// Single-port pixel memory.
// The read is registered, so data shows up the cycle after the address.
// A write and a read of the same address in one cycle return the old word.
module frame_ram #(
    parameter int WIDTH = 12,
    parameter int DEPTH_BITS = 10
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] addr,
    input  logic [WIDTH-1:0]      wdata,
    output logic [WIDTH-1:0]      rdata
);

    logic [WIDTH-1:0] mem [0:2**DEPTH_BITS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- source/led_pkg.sv
package led_pkg;

    ////////////////////////////////////////////////////////////
    // Pixel format
    ////////////////////////////////////////////////////////////

    // Bits per color channel.
    // The SPI word length and the PWM pass count both follow from it.
    parameter int COLOR_DEPTH = 4;

    // Bits per pixel on the SPI link and in every frame buffer.
    parameter int PIX_BITS = 3 * COLOR_DEPTH;

    // Red sits in the least significant bits.
    // Because the host sends LSB first, red is the first channel on the wire.
    typedef struct packed {
        logic [COLOR_DEPTH-1:0] blue;
        logic [COLOR_DEPTH-1:0] green;
        logic [COLOR_DEPTH-1:0] red;
    } pixel_t;

    ////////////////////////////////////////////////////////////
    // Block-to-block bundles
    ////////////////////////////////////////////////////////////

    // One write into the display buffers of the scanner.
    // The address travels beside it on its own bus.
    typedef struct packed {
        logic   we;
        pixel_t pix;
    } copy_word_t;

    // Everything the panel needs except the row select.
    // In each RGB field, bit 0 is red, bit 1 green and bit 2 blue.
    // The top level splits this bundle out to the pins.
    typedef struct packed {
        logic [2:0] upper_rgb;
        logic [2:0] lower_rgb;
        logic       mclk;
        logic       latch;
        logic       oe;
    } panel_drive_t;

endpackage
